// File: bench/apu_ref_model.svh
// sound core reference model
`ifndef APU_REF_MODEL_SVH
`define APU_REF_MODEL_SVH

// step i of a duty pattern uses bit i
function automatic logic duty_bit(input logic [1:0] duty, input logic [2:0] step);
    logic [7:0] pat;
    case (duty)
        2'd0:    pat = 8'b00000001;
        2'd1:    pat = 8'b10000001;
        2'd2:    pat = 8'b10000111;
        default: pat = 8'b01111110;
    endcase
    return pat[step];
endfunction

// volume code 0 mutes, 1 is full, 2 half and 3 quarter
function automatic apu_level_t wave_level(input logic [3:0] smp, input logic dac,
                                          input logic [1:0] vol);
    if (!dac) begin
        return 4'd0;
    end
    case (vol)
        2'd1:    return smp;
        2'd2:    return smp / 4'd2;
        2'd3:    return smp / 4'd4;
        default: return 4'd0;
    endcase
endfunction

function automatic logic [14:0] lfsr_step(input logic [14:0] lfsr, input logic width7);
    logic        fb;
    logic [14:0] nxt;
    fb  = lfsr[0] ^ lfsr[1];
    nxt = {fb, lfsr[14:1]};
    if (width7) begin
        nxt[6] = fb;
    end
    return nxt;
endfunction

function automatic int noise_reload(input logic [2:0] code, input logic [3:0] shift);
    int div;
    div = (code == 3'd0) ? 8 : 16 * code;
    return div << shift;
endfunction

// returns {volume, count} after one cycle
function automatic logic [6:0] env_next(input logic [3:0] vol, input logic [2:0] cnt,
                                        input logic [7:0] cfg, input logic tick);
    logic [2:0] nxt;
    nxt = cnt + 3'd1;
    if (!tick || cfg[2:0] == 3'd0) begin
        return {vol, cnt};
    end
    if (nxt != cfg[2:0]) begin
        return {vol, nxt};
    end
    if (cfg[3] && vol != 4'd15) begin
        vol = vol + 4'd1;
    end else if (!cfg[3] && vol != 4'd0) begin
        vol = vol - 4'd1;
    end
    return {vol, 3'd0};
endfunction

function automatic stereo_sample_t mix_expect(input mix_mode_t mode, input apu_level_t l0,
                                              input apu_level_t l1, input apu_level_t l2,
                                              input apu_level_t l3, input logic [5:0] ramp);
    logic [23:0] mono;
    logic [5:0]  sum;
    sum = 6'(l0) + 6'(l1) + 6'(l2) + 6'(l3);
    case (mode)
        SEL_SQ1:   mono = {l0, 20'd0};
        SEL_SQ2:   mono = {l1, 20'd0};
        SEL_WAVE:  mono = {l2, 20'd0};
        SEL_NOISE: mono = {l3, 20'd0};
        SEL_MIX:   mono = {sum, 18'd0};
        default:   mono = {ramp, 18'd0};
    endcase
    return '{left: mono, right: mono};
endfunction

`endif

// File: bench/apu_core_tb.sv
// sound core testbench
`timescale 1ns/1ps
`default_nettype none

module apu_core_tb import apu_pkg::*; ();

    `include "apu_ref_model.svh"

    localparam int STEP_DIV = 4;
    localparam int ENV_DIV  = 64;
    // upper bound of all tests in cycles
    localparam int TEST_CYCLES = 34000;

    logic           clk_100 = 1'b0;
    logic           rst_n;
    logic           reg_wr;
    apu_reg_write_t reg_data;
    logic           sample_tick;
    mix_mode_t      mix_mode;
    stereo_sample_t out_sample;
    logic           out_valid;

    // reference model state
    logic [7:0]     m_reg [256];
    logic [3:0]     wram [32];
    logic [3:0]     trig = '0;
    apu_level_t     m_lvl [4] = '{default: 4'd0};
    logic           sq_run [2] = '{default: 1'b0};
    int             sq_timer [2];
    logic [2:0]     sq_step [2];
    logic [3:0]     sq_vol [2] = '{default: 4'd0};
    logic [2:0]     sq_ecnt [2];
    logic           wave_run = 1'b0;
    int             wave_timer;
    logic [4:0]     wpos;
    logic           nz_run = 1'b0;
    int             nz_timer;
    logic [14:0]    lfsr = '1;
    logic [3:0]     nz_vol = 4'd0;
    logic [2:0]     nz_ecnt;
    logic [9:0]     ram_st1 = '0;
    logic [9:0]     ram_st2 = '0;
    logic [5:0]     ramp = '0;
    int             cyc = 0;
    logic           exp_valid = 1'b0;
    stereo_sample_t exp_sample;
    mix_mode_t      exp_mode;

    logic [31:0] rng = 32'd14922;
    string       cur_test = "reset";
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          errs_at_start;

    apu_core #(.STEP_DIV(STEP_DIV), .ENV_DIV(ENV_DIV)) UUT (
        .clk_100     (clk_100),
        .rst_n       (rst_n),
        .reg_wr      (reg_wr),
        .reg_data    (reg_data),
        .sample_tick (sample_tick),
        .mix_mode    (mix_mode),
        .out_sample  (out_sample),
        .out_valid   (out_valid)
    );

    initial begin
        forever #10 clk_100 = ~clk_100;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // model advances on the same clock edge as the DUT
    always @(posedge clk_100) begin
        logic       step;
        logic       envt;
        logic [7:0] base;
        logic [6:0] env;
        if (rst_n) begin
            step = (cyc % STEP_DIV) == STEP_DIV - 1;
            envt = step && ((cyc / STEP_DIV) % ENV_DIV) == ENV_DIV - 1;
            cyc++;
            // mixer takes the levels present in the strobe cycle
            exp_valid = sample_tick;
            if (sample_tick) begin
                exp_sample = mix_expect(mix_mode, m_lvl[0], m_lvl[1], m_lvl[2], m_lvl[3], ramp);
                exp_mode = mix_mode;
                if (mix_mode == SEL_RAMP) begin
                    ramp++;
                end
            end
            for (int i = 0; i < 2; i++) begin
                base = 8'h11 + 8'(5 * i);
                m_lvl[i] = (sq_run[i] && duty_bit(m_reg[base][7:6], sq_step[i])) ? sq_vol[i]
                                                                                  : 4'd0;
            end
            m_lvl[2] = wave_run ? wave_level(wram[wpos], m_reg[8'h1A][7], m_reg[8'h1C][6:5])
                                : 4'd0;
            m_lvl[3] = (nz_run && !lfsr[0]) ? nz_vol : 4'd0;
            for (int i = 0; i < 2; i++) begin
                base = 8'h11 + 8'(5 * i);
                if (trig[i]) begin
                    sq_run[i]   = 1'b1;
                    sq_timer[i] = 2048 - {m_reg[base + 3][2:0], m_reg[base + 2]};
                    sq_step[i]  = '0;
                    sq_vol[i]   = m_reg[base + 1][7:4];
                    sq_ecnt[i]  = '0;
                end else begin
                    if (sq_run[i] && step) begin
                        sq_timer[i]--;
                        if (sq_timer[i] == 0) begin
                            sq_timer[i] = 2048 - {m_reg[base + 3][2:0], m_reg[base + 2]};
                            sq_step[i]++;
                        end
                    end
                    env = env_next(sq_vol[i], sq_ecnt[i], m_reg[base + 1], envt);
                    {sq_vol[i], sq_ecnt[i]} = env;
                end
            end
            if (trig[2]) begin
                wave_run   = 1'b1;
                wave_timer = 2048 - {m_reg[8'h1E][2:0], m_reg[8'h1D]};
                wpos       = '0;
            end else if (wave_run && step) begin
                wave_timer--;
                if (wave_timer == 0) begin
                    wave_timer = 2048 - {m_reg[8'h1E][2:0], m_reg[8'h1D]};
                    wpos++;
                end
            end
            if (trig[3]) begin
                nz_run   = 1'b1;
                nz_timer = noise_reload(m_reg[8'h22][2:0], m_reg[8'h22][7:4]);
                lfsr     = '1;
                nz_vol   = m_reg[8'h21][7:4];
                nz_ecnt  = '0;
            end else begin
                if (nz_run && step) begin
                    nz_timer--;
                    if (nz_timer == 0) begin
                        nz_timer = noise_reload(m_reg[8'h22][2:0], m_reg[8'h22][7:4]);
                        lfsr = lfsr_step(lfsr, m_reg[8'h22][3]);
                    end
                end
                {nz_vol, nz_ecnt} = env_next(nz_vol, nz_ecnt, m_reg[8'h21], envt);
            end
            // wave RAM nibbles land one and two cycles after the byte
            if (ram_st1[9]) begin
                wram[ram_st1[8:4]] = ram_st1[3:0];
            end
            ram_st1 = ram_st2;
            ram_st2 = '0;
            trig = '0;
            if (reg_wr) begin
                if (reg_data.addr[7:4] == 4'h3) begin
                    ram_st1 = {1'b1, reg_data.addr[3:0], 1'b0, reg_data.data[7:4]};
                    ram_st2 = {1'b1, reg_data.addr[3:0], 1'b1, reg_data.data[3:0]};
                end else begin
                    m_reg[reg_data.addr] = reg_data.data;
                    trig[0] = reg_data.addr == 8'h14 && reg_data.data[7];
                    trig[1] = reg_data.addr == 8'h19 && reg_data.data[7];
                    trig[2] = reg_data.addr == 8'h1E && reg_data.data[7];
                    trig[3] = reg_data.addr == 8'h23 && reg_data.data[7];
                end
            end
        end
    end

    task automatic check_sample(input string name, input stereo_sample_t exp,
                                input stereo_sample_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected sample %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_level(input string name, input apu_level_t exp, input apu_level_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected level %0d actual %0d", name, exp, act);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_100) begin
        if (rst_n) begin
            if (out_valid !== exp_valid) begin
                errors++;
                if (out_valid === 1'b1) begin
                    $display("%s: out_valid came without a sample_tick one cycle before",
                             cur_test);
                end else begin
                    $display("%s: a sample_tick produced no out_valid", cur_test);
                end
            end else if (exp_valid) begin
                check_sample(cur_test, exp_sample, out_sample);
                if (exp_mode < SEL_MIX) begin
                    check_level(cur_test, exp_sample.left[23:20], out_sample.left[23:20]);
                end
            end
        end
    end

    initial begin
        #(2 * TEST_CYCLES * 20);
        $display("watchdog expired in test %s", cur_test);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        @(negedge clk_100);
        reg_wr   = 1'b1;
        reg_data = '{addr: addr, data: data};
        @(negedge clk_100);
        reg_wr   = 1'b0;
    endtask

    // gap 0 gives strobes on adjacent cycles
    task automatic run_samples(input mix_mode_t mode, input int n, input int max_gap);
        int gap;
        for (int k = 0; k < n; k++) begin
            gap = next_rand() % (max_gap + 1);
            repeat (gap) begin
                @(negedge clk_100);
                sample_tick = 1'b0;
            end
            @(negedge clk_100);
            sample_tick = 1'b1;
            mix_mode    = mode;
        end
        @(negedge clk_100);
        sample_tick = 1'b0;
        @(negedge clk_100);
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        errs_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == errs_at_start) begin
            $display("%s: passed", cur_test);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", cur_test, errors - errs_at_start);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        reg_wr      = 1'b0;
        reg_data    = '0;
        sample_tick = 1'b0;
        mix_mode    = SEL_RAMP;
        foreach (m_reg[i]) begin
            m_reg[i] = 8'h00;
        end
        repeat (3) @(posedge clk_100);
        @(negedge clk_100);
        rst_n = 1'b1;

        begin_test("ramp");
        run_samples(SEL_RAMP, 70, 3);
        end_test();

        begin_test("square duty");
        run_samples(SEL_SQ1, 8, 15);
        run_samples(SEL_SQ2, 8, 15);
        for (int ch = 0; ch < 2; ch++) begin
            for (int d = 0; d < 4; d++) begin
                write_reg(8'h11 + 8'(5 * ch), 8'(d << 6));
                write_reg(8'h12 + 8'(5 * ch), 8'hA0);
                write_reg(8'h13 + 8'(5 * ch), 8'hF8);
                write_reg(8'h14 + 8'(5 * ch), 8'h87);
                run_samples(ch == 0 ? SEL_SQ1 : SEL_SQ2, 48, 15);
            end
        end
        end_test();

        begin_test("envelope");
        write_reg(8'h11, 8'h80);
        write_reg(8'h12, 8'h29);
        write_reg(8'h14, 8'h87);
        run_samples(SEL_SQ1, 150, 63);
        write_reg(8'h12, 8'h31);
        write_reg(8'h14, 8'h87);
        run_samples(SEL_SQ1, 60, 63);
        end_test();

        begin_test("wave");
        for (int a = 0; a < 16; a++) begin
            write_reg(8'h30 + 8'(a), 8'(next_rand()));
        end
        write_reg(8'h1A, 8'h80);
        write_reg(8'h1D, 8'hFC);
        for (int v = 0; v < 4; v++) begin
            write_reg(8'h1C, 8'(v << 5));
            write_reg(8'h1E, 8'h87);
            run_samples(SEL_WAVE, 64, 15);
        end
        write_reg(8'h1A, 8'h00);
        run_samples(SEL_WAVE, 64, 15);
        write_reg(8'h1A, 8'h80);
        end_test();

        begin_test("noise");
        write_reg(8'h21, 8'hF0);
        write_reg(8'h22, 8'h00);
        write_reg(8'h23, 8'h80);
        run_samples(SEL_NOISE, 100, 15);
        write_reg(8'h22, 8'h19);
        write_reg(8'h23, 8'h80);
        run_samples(SEL_NOISE, 100, 15);
        write_reg(8'h22, 8'h02);
        write_reg(8'h23, 8'h80);
        run_samples(SEL_NOISE, 100, 15);
        write_reg(8'h22, 8'h28);
        write_reg(8'h23, 8'h80);
        run_samples(SEL_NOISE, 100, 15);
        end_test();

        begin_test("mix");
        write_reg(8'h12, 8'hF0);
        write_reg(8'h14, 8'h87);
        write_reg(8'h1C, 8'h20);
        run_samples(SEL_MIX, 200, 3);
        end_test();

        repeat (4) @(negedge clk_100);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/apu_core.sv
// sound processor top level
`timescale 1ns/1ps
`default_nettype none

module apu_core import apu_pkg::*; #(
    parameter int STEP_DIV = 4,
    parameter int ENV_DIV  = 8192
) (
    input  logic           clk_100,
    input  logic           rst_n,
    input  logic           reg_wr,
    input  apu_reg_write_t reg_data,
    input  logic           sample_tick,
    input  mix_mode_t      mix_mode,
    output stereo_sample_t out_sample,
    output logic           out_valid
);

    square_cfg_t     sq1_cfg;
    square_cfg_t     sq2_cfg;
    wave_cfg_t       wave_cfg;
    noise_cfg_t      noise_cfg;
    logic            sq1_trig;
    logic            sq2_trig;
    logic            wave_trig;
    logic            noise_trig;
    logic            wave_wr;
    wave_ram_write_t wave_wr_data;
    logic            step_tick;
    logic            env_tick;
    apu_levels_t     levels;

    apu_regs u_regs (
        .clk_100      (clk_100),
        .rst_n        (rst_n),
        .reg_wr       (reg_wr),
        .reg_data     (reg_data),
        .sq1_cfg      (sq1_cfg),
        .sq2_cfg      (sq2_cfg),
        .wave_cfg     (wave_cfg),
        .noise_cfg    (noise_cfg),
        .sq1_trig     (sq1_trig),
        .sq2_trig     (sq2_trig),
        .wave_trig    (wave_trig),
        .noise_trig   (noise_trig),
        .wave_wr      (wave_wr),
        .wave_wr_data (wave_wr_data)
    );

    apu_timebase #(
        .STEP_DIV (STEP_DIV),
        .ENV_DIV  (ENV_DIV)
    ) u_timebase (
        .clk_100   (clk_100),
        .rst_n     (rst_n),
        .step_tick (step_tick),
        .env_tick  (env_tick)
    );

    square_channel u_sq1 (
        .clk_100   (clk_100),
        .rst_n     (rst_n),
        .step_tick (step_tick),
        .env_tick  (env_tick),
        .trig      (sq1_trig),
        .cfg       (sq1_cfg),
        .level     (levels.sq1)
    );

    square_channel u_sq2 (
        .clk_100   (clk_100),
        .rst_n     (rst_n),
        .step_tick (step_tick),
        .env_tick  (env_tick),
        .trig      (sq2_trig),
        .cfg       (sq2_cfg),
        .level     (levels.sq2)
    );

    wave_channel u_wave (
        .clk_100     (clk_100),
        .rst_n       (rst_n),
        .step_tick   (step_tick),
        .trig        (wave_trig),
        .cfg         (wave_cfg),
        .ram_wr      (wave_wr),
        .ram_wr_data (wave_wr_data),
        .level       (levels.wave)
    );

    noise_channel u_noise (
        .clk_100   (clk_100),
        .rst_n     (rst_n),
        .step_tick (step_tick),
        .env_tick  (env_tick),
        .trig      (noise_trig),
        .cfg       (noise_cfg),
        .level     (levels.noise)
    );

    sample_mixer u_mixer (
        .clk_100      (clk_100),
        .rst_n        (rst_n),
        .sample_tick  (sample_tick),
        .mode         (mix_mode),
        .levels       (levels),
        .sample       (out_sample),
        .sample_valid (out_valid)
    );

endmodule

`default_nettype wire

// File: rtl/apu_pkg.sv
// sound processor shared types
`default_nettype none

package apu_pkg;

    typedef logic [3:0] apu_level_t;

    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data;
    } apu_reg_write_t;

    // same bit order as the NRx2 register byte
    typedef struct packed {
        logic [3:0] init_vol;
        logic       dir_up;
        logic [2:0] period;
    } envelope_cfg_t;

    typedef struct packed {
        logic [10:0]   freq;
        logic [1:0]    duty;
        envelope_cfg_t env;
    } square_cfg_t;

    typedef struct packed {
        logic [10:0] freq;
        logic        dac_en;
        logic [1:0]  vol;
    } wave_cfg_t;

    typedef struct packed {
        logic [4:0] index;
        logic [3:0] sample;
    } wave_ram_write_t;

    typedef struct packed {
        logic [3:0]    shift;
        logic          width7;
        logic [2:0]    div;
        envelope_cfg_t env;
    } noise_cfg_t;

    typedef struct packed {
        apu_level_t sq1;
        apu_level_t sq2;
        apu_level_t wave;
        apu_level_t noise;
    } apu_levels_t;

    typedef enum logic [2:0] {
        SEL_SQ1,
        SEL_SQ2,
        SEL_WAVE,
        SEL_NOISE,
        SEL_MIX,
        SEL_RAMP
    } mix_mode_t;

    typedef struct packed {
        logic [23:0] left;
        logic [23:0] right;
    } stereo_sample_t;

    // register map
    localparam logic [7:0] NR11_ADDR = 8'h11;
    localparam logic [7:0] NR12_ADDR = 8'h12;
    localparam logic [7:0] NR13_ADDR = 8'h13;
    localparam logic [7:0] NR14_ADDR = 8'h14;
    localparam logic [7:0] NR21_ADDR = 8'h16;
    localparam logic [7:0] NR22_ADDR = 8'h17;
    localparam logic [7:0] NR23_ADDR = 8'h18;
    localparam logic [7:0] NR24_ADDR = 8'h19;
    localparam logic [7:0] NR30_ADDR = 8'h1A;
    localparam logic [7:0] NR32_ADDR = 8'h1C;
    localparam logic [7:0] NR33_ADDR = 8'h1D;
    localparam logic [7:0] NR34_ADDR = 8'h1E;
    localparam logic [7:0] NR42_ADDR = 8'h21;
    localparam logic [7:0] NR43_ADDR = 8'h22;
    localparam logic [7:0] NR44_ADDR = 8'h23;
    // wave RAM occupies 0x30..0x3F
    localparam logic [3:0] WAVE_RAM_PAGE = 4'h3;

    // step i of the duty sequencer uses bit i
    localparam logic [3:0][7:0] DUTY_TABLE = {
        8'b01111110, 8'b10000111, 8'b10000001, 8'b00000001
    };

    localparam logic [7:0][6:0] NOISE_DIVISOR = {
        7'd112, 7'd96, 7'd80, 7'd64, 7'd48, 7'd32, 7'd16, 7'd8
    };

endpackage

`default_nettype wire

// File: rtl/apu_regs.sv
// register write decoder
`timescale 1ns/1ps
`default_nettype none

module apu_regs import apu_pkg::*; (
    input  logic            clk_100,
    input  logic            rst_n,
    input  logic            reg_wr,
    input  apu_reg_write_t  reg_data,
    output square_cfg_t     sq1_cfg,
    output square_cfg_t     sq2_cfg,
    output wave_cfg_t       wave_cfg,
    output noise_cfg_t      noise_cfg,
    output logic            sq1_trig,
    output logic            sq2_trig,
    output logic            wave_trig,
    output logic            noise_trig,
    output logic            wave_wr,
    output wave_ram_write_t wave_wr_data
);

    logic            ram_hit;
    logic            lo_pend;
    wave_ram_write_t lo_data;

    assign ram_hit = reg_wr && (reg_data.addr[7:4] == WAVE_RAM_PAGE);

    always_ff @(posedge clk_100 or negedge rst_n) begin
        if (!rst_n) begin
            sq1_cfg    <= '0;
            sq2_cfg    <= '0;
            wave_cfg   <= '0;
            noise_cfg  <= '0;
            sq1_trig   <= 1'b0;
            sq2_trig   <= 1'b0;
            wave_trig  <= 1'b0;
            noise_trig <= 1'b0;
        end else begin
            // trigger strobes last one cycle
            sq1_trig   <= 1'b0;
            sq2_trig   <= 1'b0;
            wave_trig  <= 1'b0;
            noise_trig <= 1'b0;
            if (reg_wr) begin
                case (reg_data.addr)
                    NR11_ADDR: sq1_cfg.duty <= reg_data.data[7:6];
                    NR12_ADDR: sq1_cfg.env <= reg_data.data;
                    NR13_ADDR: sq1_cfg.freq[7:0] <= reg_data.data;
                    NR14_ADDR: begin
                        sq1_cfg.freq[10:8] <= reg_data.data[2:0];
                        sq1_trig <= reg_data.data[7];
                    end
                    NR21_ADDR: sq2_cfg.duty <= reg_data.data[7:6];
                    NR22_ADDR: sq2_cfg.env <= reg_data.data;
                    NR23_ADDR: sq2_cfg.freq[7:0] <= reg_data.data;
                    NR24_ADDR: begin
                        sq2_cfg.freq[10:8] <= reg_data.data[2:0];
                        sq2_trig <= reg_data.data[7];
                    end
                    NR30_ADDR: wave_cfg.dac_en <= reg_data.data[7];
                    NR32_ADDR: wave_cfg.vol <= reg_data.data[6:5];
                    NR33_ADDR: wave_cfg.freq[7:0] <= reg_data.data;
                    NR34_ADDR: begin
                        wave_cfg.freq[10:8] <= reg_data.data[2:0];
                        wave_trig <= reg_data.data[7];
                    end
                    NR42_ADDR: noise_cfg.env <= reg_data.data;
                    NR43_ADDR: begin
                        noise_cfg.shift  <= reg_data.data[7:4];
                        noise_cfg.width7 <= reg_data.data[3];
                        noise_cfg.div    <= reg_data.data[2:0];
                    end
                    NR44_ADDR: noise_trig <= reg_data.data[7];
                    default: ;
                endcase
            end
        end
    end

    // wave RAM byte goes out as two nibble writes, high nibble first
    always_ff @(posedge clk_100 or negedge rst_n) begin
        if (!rst_n) begin
            wave_wr <= 1'b0;
            lo_pend <= 1'b0;
        end else begin
            wave_wr <= ram_hit || lo_pend;
            lo_pend <= ram_hit;
        end
    end

    always_ff @(posedge clk_100) begin
        if (ram_hit) begin
            wave_wr_data <= '{index: {reg_data.addr[3:0], 1'b0}, sample: reg_data.data[7:4]};
            lo_data      <= '{index: {reg_data.addr[3:0], 1'b1}, sample: reg_data.data[3:0]};
        end else if (lo_pend) begin
            wave_wr_data <= lo_data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/apu_timebase.sv
// channel step and envelope timing
`timescale 1ns/1ps
`default_nettype none

module apu_timebase #(
    parameter int STEP_DIV = 4,
    parameter int ENV_DIV  = 8192
) (
    input  logic clk_100,
    input  logic rst_n,
    output logic step_tick,
    output logic env_tick
);

    localparam int STEP_W = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;
    localparam int ENV_W  = (ENV_DIV > 1) ? $clog2(ENV_DIV) : 1;

    logic [STEP_W-1:0] step_cnt;
    logic [ENV_W-1:0]  env_cnt;

    assign step_tick = (step_cnt == STEP_W'(STEP_DIV - 1));
    assign env_tick  = step_tick && (env_cnt == ENV_W'(ENV_DIV - 1));

    always_ff @(posedge clk_100 or negedge rst_n) begin
        if (!rst_n) begin
            step_cnt <= '0;
            env_cnt  <= '0;
        end else begin
            step_cnt <= step_tick ? '0 : step_cnt + 1'b1;
            // second stage counts step ticks only
            if (step_tick) begin
                env_cnt <= env_tick ? '0 : env_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/noise_channel.sv
// noise voice
`timescale 1ns/1ps
`default_nettype none

module noise_channel import apu_pkg::*; (
    input  logic       clk_100,
    input  logic       rst_n,
    input  logic       step_tick,
    input  logic       env_tick,
    input  logic       trig,
    input  noise_cfg_t cfg,
    output apu_level_t level
);

    logic        running;
    logic [14:0] lfsr;
    logic [14:0] lfsr_next;
    logic        fb;
    logic [21:0] timer;
    logic [21:0] reload;
    apu_level_t  volume;

    assign reload = {15'd0, NOISE_DIVISOR[cfg.div]} << cfg.shift;
    assign fb     = lfsr[0] ^ lfsr[1];

    always_comb begin
        lfsr_next = {fb, lfsr[14:1]};
        // short mode also feeds bit 6
        if (cfg.width7) begin
            lfsr_next[6] = fb;
        end
    end

    volume_envelope u_env (
        .clk_100  (clk_100),
        .rst_n    (rst_n),
        .env_tick (env_tick),
        .trig     (trig),
        .cfg      (cfg.env),
        .volume   (volume)
    );

    always_ff @(posedge clk_100 or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            lfsr    <= '1;
            timer   <= '0;
            level   <= '0;
        end else begin
            if (trig) begin
                running <= 1'b1;
                lfsr    <= '1;
                timer   <= reload;
            end else if (running && step_tick) begin
                if (timer == 22'd1) begin
                    timer <= reload;
                    lfsr  <= lfsr_next;
                end else begin
                    timer <= timer - 1'b1;
                end
            end
            level <= (running && !lfsr[0]) ? volume : 4'd0;
        end
    end

    a_lfsr_alive: assert property (
        @(posedge clk_100) disable iff (!rst_n)
        lfsr != '0
    ) else $error("noise LFSR reached all zeros");

endmodule

`default_nettype wire

// File: rtl/sample_mixer.sv
// output sample selector
`timescale 1ns/1ps
`default_nettype none

module sample_mixer import apu_pkg::*; (
    input  logic           clk_100,
    input  logic           rst_n,
    input  logic           sample_tick,
    input  mix_mode_t      mode,
    input  apu_levels_t    levels,
    output stereo_sample_t sample,
    output logic           sample_valid
);

    logic [5:0]  ramp;
    logic [5:0]  mix_sum;
    logic [23:0] mono;

    assign mix_sum = {2'b00, levels.sq1} + {2'b00, levels.sq2}
                   + {2'b00, levels.wave} + {2'b00, levels.noise};

    always_comb begin
        case (mode)
            SEL_SQ1:   mono = {levels.sq1, 20'd0};
            SEL_SQ2:   mono = {levels.sq2, 20'd0};
            SEL_WAVE:  mono = {levels.wave, 20'd0};
            SEL_NOISE: mono = {levels.noise, 20'd0};
            SEL_MIX:   mono = {mix_sum, 18'd0};
            SEL_RAMP:  mono = {ramp, 18'd0};
            default:   mono = '0;
        endcase
    end

    always_ff @(posedge clk_100 or negedge rst_n) begin
        if (!rst_n) begin
            sample_valid <= 1'b0;
            ramp         <= '0;
        end else begin
            sample_valid <= sample_tick;
            // ramp advances only on samples taken in ramp mode
            if (sample_tick && mode == SEL_RAMP) begin
                ramp <= ramp + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100) begin
        if (sample_tick) begin
            sample.left  <= mono;
            sample.right <= mono;
        end
    end

    a_valid_follows_tick: assert property (
        @(posedge clk_100) disable iff (!rst_n)
        sample_valid |-> $past(sample_tick)
    ) else $error("sample_valid without a sample_tick one cycle earlier");

endmodule

`default_nettype wire

// File: rtl/square_channel.sv
// square wave voice
`timescale 1ns/1ps
`default_nettype none

module square_channel import apu_pkg::*; (
    input  logic        clk_100,
    input  logic        rst_n,
    input  logic        step_tick,
    input  logic        env_tick,
    input  logic        trig,
    input  square_cfg_t cfg,
    output apu_level_t  level
);

    logic        running;
    logic [11:0] timer;
    logic [11:0] reload;
    logic [2:0]  step;
    apu_level_t  volume;

    // period in step ticks is 2048 minus the frequency code
    assign reload = 12'd2048 - {1'b0, cfg.freq};

    volume_envelope u_env (
        .clk_100  (clk_100),
        .rst_n    (rst_n),
        .env_tick (env_tick),
        .trig     (trig),
        .cfg      (cfg.env),
        .volume   (volume)
    );

    always_ff @(posedge clk_100 or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            timer   <= '0;
            step    <= '0;
            level   <= '0;
        end else begin
            if (trig) begin
                running <= 1'b1;
                timer   <= reload;
                step    <= '0;
            end else if (running && step_tick) begin
                if (timer == 12'd1) begin
                    timer <= reload;
                    step  <= step + 1'b1;
                end else begin
                    timer <= timer - 1'b1;
                end
            end
            level <= (running && DUTY_TABLE[cfg.duty][step]) ? volume : 4'd0;
        end
    end

    // reload happens on the tick that would reach zero
    a_timer_nonzero: assert property (
        @(posedge clk_100) disable iff (!rst_n)
        (running && step_tick) |-> (timer != '0)
    ) else $error("square timer holds zero on a step tick");

endmodule

`default_nettype wire

// File: rtl/volume_envelope.sv
// volume envelope
`timescale 1ns/1ps
`default_nettype none

module volume_envelope import apu_pkg::*; (
    input  logic          clk_100,
    input  logic          rst_n,
    input  logic          env_tick,
    input  logic          trig,
    input  envelope_cfg_t cfg,
    output apu_level_t    volume
);

    logic [2:0] env_cnt;
    logic [2:0] cnt_next;

    assign cnt_next = env_cnt + 1'b1;

    always_ff @(posedge clk_100 or negedge rst_n) begin
        if (!rst_n) begin
            volume  <= '0;
            env_cnt <= '0;
        end else if (trig) begin
            volume  <= cfg.init_vol;
            env_cnt <= '0;
        end else if (env_tick && cfg.period != 3'd0) begin
            if (cnt_next == cfg.period) begin
                env_cnt <= '0;
                // saturate at the ends of the range
                if (cfg.dir_up && volume != 4'd15) begin
                    volume <= volume + 1'b1;
                end else if (!cfg.dir_up && volume != 4'd0) begin
                    volume <= volume - 1'b1;
                end
            end else begin
                env_cnt <= cnt_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/wave_channel.sv
// wave table voice
`timescale 1ns/1ps
`default_nettype none

module wave_channel import apu_pkg::*; (
    input  logic            clk_100,
    input  logic            rst_n,
    input  logic            step_tick,
    input  logic            trig,
    input  wave_cfg_t       cfg,
    input  logic            ram_wr,
    input  wave_ram_write_t ram_wr_data,
    output apu_level_t      level
);

    logic [3:0]  pattern [32];
    logic        running;
    logic [11:0] timer;
    logic [11:0] reload;
    logic [4:0]  pos;
    logic [3:0]  cur_sample;

    assign reload     = 12'd2048 - {1'b0, cfg.freq};
    assign cur_sample = pattern[pos];

    always_ff @(posedge clk_100) begin
        if (ram_wr) begin
            pattern[ram_wr_data.index] <= ram_wr_data.sample;
        end
    end

    always_ff @(posedge clk_100 or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            timer   <= '0;
            pos     <= '0;
            level   <= '0;
        end else begin
            if (trig) begin
                running <= 1'b1;
                timer   <= reload;
                pos     <= '0;
            end else if (running && step_tick) begin
                if (timer == 12'd1) begin
                    timer <= reload;
                    pos   <= pos + 1'b1;
                end else begin
                    timer <= timer - 1'b1;
                end
            end
            // code 1 full, 2 half, 3 quarter
            if (running && cfg.dac_en && cfg.vol != 2'd0) begin
                level <= cur_sample >> (cfg.vol - 2'd1);
            end else begin
                level <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+bench
rtl/apu_pkg.sv
rtl/apu_regs.sv
rtl/apu_timebase.sv
rtl/volume_envelope.sv
rtl/square_channel.sv
rtl/wave_channel.sv
rtl/noise_channel.sv
rtl/sample_mixer.sv
rtl/apu_core.sv
bench/apu_core_tb.sv
